// File: source/bep_defs.svh
`ifndef BEP_DEFS_SVH
`define BEP_DEFS_SVH

// datapath widths
`define BEP_XLEN      32
`define BEP_REG_AW    5
`define BEP_TIMER_W   64
`define BEP_CSR_AW    14
`define BEP_IMM_W     12
`define BEP_INSTR_W   26  // low instruction bits carried down the pipe

// ex, m1, m2, wb
`define BEP_STAGE_NUM 4
`define BEP_FWD_NUM   (`BEP_STAGE_NUM - 1)  // forward taps per pipe: m1, m2, wb

// op code field widths
`define BEP_ALU_OP_W  4
`define BEP_CSR_OP_W  2

// csr numbers
`define BEP_CSR_SAVE0 14'h30
`define BEP_CSR_SAVE1 14'h31
`define BEP_CSR_TID   14'h40

`endif

// File: source/bep_pkg.sv
`include "bep_defs.svh"

package bep_pkg;

	typedef enum logic [`BEP_ALU_OP_W-1:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef enum logic {WB_ALU, WB_CSR} wb_sel_e;  // m2 result source

	typedef enum logic [`BEP_CSR_OP_W-1:0] {CSR_NONE, CSR_RD, CSR_WR, CSR_XCHG} csr_op_e;

	// same 26 bits, two decodings
	typedef struct packed {
		logic [`BEP_INSTR_W-`BEP_IMM_W-2*`BEP_REG_AW-1:0] hi;
		logic [`BEP_IMM_W-1:0]                            imm;  // inst[21:10]
		logic [2*`BEP_REG_AW-1:0]                         regs;
	} alu_field_t;

	typedef struct packed {
		logic [`BEP_INSTR_W-`BEP_CSR_AW-2*`BEP_REG_AW-1:0] hi;
		logic [`BEP_CSR_AW-1:0]                            num;  // inst[23:10]
		logic [2*`BEP_REG_AW-1:0]                          regs;
	} csr_field_t;

	typedef union packed {
		alu_field_t alu;
		csr_field_t csr;
	} instr_field_u;

	// one-hot selects, bit 0 is the stage's own operand
	typedef struct packed {
		logic                     pipe_sel;
		logic [`BEP_FWD_NUM:0]    ex_src;  // own/m1/m2/wb
		logic [`BEP_FWD_NUM-1:0]  m1_src;  // own/m2/wb
		logic [`BEP_FWD_NUM-2:0]  m2_src;  // own/wb
	} fwd_sel_t;

	typedef struct packed {
		logic                   valid;
		alu_op_e                alu_op;
		logic                   use_imm;
		wb_sel_e                wb_sel;
		csr_op_e                csr_op;
		logic [`BEP_REG_AW-1:0] w_reg;
		instr_field_u           instr;
		fwd_sel_t [1:0]         fwd;  // [0] rd, [1] rj
	} ctrl_flow_t;

	typedef struct packed {
		logic [`BEP_XLEN-1:0]       pc;
		logic [1:0][`BEP_XLEN-1:0]  reg_data;  // [0] rd, [1] rj
		logic [`BEP_XLEN-1:0]       result;
	} data_flow_t;

	// index 0 is m1, 1 is m2, 2 is wb
	typedef logic [`BEP_FWD_NUM-1:0][`BEP_XLEN-1:0] fwd_vals_t;

	typedef struct packed {
		fwd_vals_t pipe1;
		fwd_vals_t pipe0;
	} fwd_src_t;

	typedef struct packed {
		logic [`BEP_XLEN-1:0] wb;
		logic [`BEP_XLEN-1:0] m2;
		logic [`BEP_XLEN-1:0] m1;
	} fwd_out_t;

	typedef struct packed {
		logic [`BEP_REG_AW-1:0] addr;
		logic [`BEP_XLEN-1:0]   data;
	} reg_wr_t;

	typedef struct packed {
		logic                   commit;  // write takes effect at the end of this m2 cycle
		csr_op_e                op;
		logic [`BEP_CSR_AW-1:0] num;
		logic [`BEP_XLEN-1:0]   wdata;   // rd operand
		logic [`BEP_XLEN-1:0]   wmask;   // rj operand
	} csr_req_t;

endpackage

// File: source/operand_forward.sv
`include "bep_defs.svh"
`timescale 1ns/1ps

module operand_forward #(
	parameter int SOURCE_NUM = 3
)(
	input  logic                                  pipe_sel_i,
	input  logic [SOURCE_NUM:0]                   sel_i,        // [0] own, then nearest tap first
	input  logic [SOURCE_NUM-1:0][`BEP_XLEN-1:0]  src_pipe0_i,
	input  logic [SOURCE_NUM-1:0][`BEP_XLEN-1:0]  src_pipe1_i,
	input  logic [`BEP_XLEN-1:0]                  own_i,
	output logic [`BEP_XLEN-1:0]                  data_o
);

	logic [SOURCE_NUM-1:0][`BEP_XLEN-1:0] pipe_vals;

	assign pipe_vals = pipe_sel_i ? src_pipe1_i : src_pipe0_i;

	// and-or mux, sel_i is one-hot for a valid stage
	always_comb begin
		logic [`BEP_XLEN-1:0] acc;
		acc = own_i & {`BEP_XLEN{sel_i[0]}};
		for (int i = 0; i < SOURCE_NUM; i++) begin
			acc |= pipe_vals[i] & {`BEP_XLEN{sel_i[i+1]}};
		end
		data_o = acc;
	end

endmodule

// File: source/exec_alu.sv
`include "bep_defs.svh"
`timescale 1ns/1ps

module exec_alu (
	input  bep_pkg::ctrl_flow_t   ctrl_i,
	input  logic [`BEP_XLEN-1:0]  opnd_rj_i,
	input  logic [`BEP_XLEN-1:0]  opnd_rd_i,
	output logic [`BEP_XLEN-1:0]  alu_result_o
);

	logic [`BEP_IMM_W-1:0] imm;
	logic [`BEP_XLEN-1:0]  imm_sext;
	logic [`BEP_XLEN-1:0]  op_a, op_b;
	logic [4:0]            shamt;

	assign imm = ctrl_i.instr.alu.imm;
	assign imm_sext = {{(`BEP_XLEN-`BEP_IMM_W){imm[`BEP_IMM_W-1]}}, imm};

	assign op_a = opnd_rj_i;
	assign op_b = ctrl_i.use_imm ? imm_sext : opnd_rd_i;
	assign shamt = op_b[4:0];  // only low 5 bits shift

	always_comb begin
		case (ctrl_i.alu_op)
			bep_pkg::ALU_ADD:  alu_result_o = op_a + op_b;
			bep_pkg::ALU_SUB:  alu_result_o = op_a - op_b;
			bep_pkg::ALU_AND:  alu_result_o = op_a & op_b;
			bep_pkg::ALU_OR:   alu_result_o = op_a | op_b;
			bep_pkg::ALU_XOR:  alu_result_o = op_a ^ op_b;
			bep_pkg::ALU_SLT: begin
				alu_result_o = {{(`BEP_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			end
			bep_pkg::ALU_SLTU: begin
				alu_result_o = {{(`BEP_XLEN-1){1'b0}}, op_a < op_b};
			end
			bep_pkg::ALU_SLL:  alu_result_o = op_a << shamt;
			bep_pkg::ALU_SRL:  alu_result_o = op_a >> shamt;
			bep_pkg::ALU_SRA:  alu_result_o = $signed(op_a) >>> shamt;
			// upper immediate, low bits cleared
			bep_pkg::ALU_LUI:  alu_result_o = imm_sext << (`BEP_XLEN - `BEP_IMM_W);
			default:           alu_result_o = '0;
		endcase
	end

endmodule

// File: source/csr_file.sv
`include "bep_defs.svh"
`timescale 1ns/1ps

module csr_file (
	input  logic                     clk,
	input  logic                     rst_n,
	input  bep_pkg::csr_req_t        csr_req_i,
	output logic [`BEP_XLEN-1:0]     csr_rdata_o,
	output logic [`BEP_TIMER_W-1:0]  timer_data_o,
	output logic [`BEP_XLEN-1:0]     tid_o
);

	logic [`BEP_XLEN-1:0]     save0_q, save1_q, tid_q;
	logic [`BEP_TIMER_W-1:0]  timer_q;
	logic [`BEP_XLEN-1:0]     wr_val;
	logic                     wr_en;

	// every op hands back the value before the write
	always_comb begin
		case (csr_req_i.num)
			`BEP_CSR_SAVE0: csr_rdata_o = save0_q;
			`BEP_CSR_SAVE1: csr_rdata_o = save1_q;
			`BEP_CSR_TID:   csr_rdata_o = tid_q;
			default:        csr_rdata_o = '0;  // unmapped
		endcase
	end

	assign wr_en = csr_req_i.commit
		&& (csr_req_i.op == bep_pkg::CSR_WR || csr_req_i.op == bep_pkg::CSR_XCHG);

	// xchg only touches the bits set in the mask
	assign wr_val = (csr_req_i.op == bep_pkg::CSR_XCHG)
		? (csr_rdata_o & ~csr_req_i.wmask) | (csr_req_i.wdata & csr_req_i.wmask)
		: csr_req_i.wdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			save0_q <= '0;
			save1_q <= '0;
			tid_q <= '0;
		end else if (wr_en) begin
			case (csr_req_i.num)
				`BEP_CSR_SAVE0: save0_q <= wr_val;
				`BEP_CSR_SAVE1: save1_q <= wr_val;
				`BEP_CSR_TID:   tid_q <= wr_val;
				default:        ;  // write dropped
			endcase
		end
	end

	// free-running stable counter
	always_ff @(posedge clk) begin
		if (!rst_n) timer_q <= '0;
		else timer_q <= timer_q + 1'b1;
	end

	assign timer_data_o = timer_q;
	assign tid_o = tid_q;

	// m2 only commits instructions decoded as csr ops
	a_commit_op: assert property (@(posedge clk) disable iff (!rst_n)
		csr_req_i.commit |-> csr_req_i.op != bep_pkg::CSR_NONE);

endmodule

// File: source/stage_regs.sv
`include "bep_defs.svh"
`timescale 1ns/1ps

module stage_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue_i,
	input  bep_pkg::ctrl_flow_t   ctrl_flow_i,
	input  bep_pkg::data_flow_t   data_flow_i,
	input  logic [2:0]            stall_vec_i,
	input  logic [2:0]            clr_vec_i,
	input  bep_pkg::fwd_src_t     forwarding_src_i,
	input  logic [`BEP_XLEN-1:0]  alu_result_i,
	input  logic [`BEP_XLEN-1:0]  csr_rdata_i,
	output bep_pkg::ctrl_flow_t   ex_ctrl_o,
	output logic [`BEP_XLEN-1:0]  ex_rj_o,
	output logic [`BEP_XLEN-1:0]  ex_rd_o,
	output bep_pkg::csr_req_t     csr_req_o,
	output bep_pkg::fwd_out_t     forwarding_data_o,
	output bep_pkg::reg_wr_t      reg_wr_o
);

	bep_pkg::ctrl_flow_t ex_ctrl, m1_ctrl, m2_ctrl, wb_ctrl;
	bep_pkg::data_flow_t ex_raw, m1_raw, m2_raw, wb_data;
	bep_pkg::data_flow_t ex_fwd, m1_fwd, m2_fwd;  // raw word with forwarded operands
	logic [1:0][`BEP_XLEN-1:0] ex_opnd, m1_opnd, m2_opnd;

	// held stage keeps what it captured, so every select goes back to own
	function automatic bep_pkg::fwd_sel_t to_own(bep_pkg::fwd_sel_t s);
		bep_pkg::fwd_sel_t o;
		o = s;
		o.ex_src = 1;
		o.m1_src = 1;
		o.m2_src = 1;
		return o;
	endfunction

	for (genvar r = 0; r < 2; r++) begin : g_fwd
		operand_forward #(.SOURCE_NUM(3)) u_ex_fwd (
			.pipe_sel_i(ex_ctrl.fwd[r].pipe_sel), .sel_i(ex_ctrl.fwd[r].ex_src),
			.src_pipe0_i(forwarding_src_i.pipe0), .src_pipe1_i(forwarding_src_i.pipe1),
			.own_i(ex_raw.reg_data[r]), .data_o(ex_opnd[r]));
		operand_forward #(.SOURCE_NUM(2)) u_m1_fwd (
			.pipe_sel_i(m1_ctrl.fwd[r].pipe_sel), .sel_i(m1_ctrl.fwd[r].m1_src),
			.src_pipe0_i(forwarding_src_i.pipe0[2:1]), .src_pipe1_i(forwarding_src_i.pipe1[2:1]),
			.own_i(m1_raw.reg_data[r]), .data_o(m1_opnd[r]));
		operand_forward #(.SOURCE_NUM(1)) u_m2_fwd (
			.pipe_sel_i(m2_ctrl.fwd[r].pipe_sel), .sel_i(m2_ctrl.fwd[r].m2_src),
			.src_pipe0_i(forwarding_src_i.pipe0[2:2]), .src_pipe1_i(forwarding_src_i.pipe1[2:2]),
			.own_i(m2_raw.reg_data[r]), .data_o(m2_opnd[r]));

		// hazard unit must hand over a legal select for anything live
		a_ex_sel: assert property (@(posedge clk) disable iff (!rst_n)
			ex_ctrl.valid |-> $onehot(ex_ctrl.fwd[r].ex_src));
		a_m1_sel: assert property (@(posedge clk) disable iff (!rst_n)
			m1_ctrl.valid |-> $onehot(m1_ctrl.fwd[r].m1_src));
		a_m2_sel: assert property (@(posedge clk) disable iff (!rst_n)
			m2_ctrl.valid |-> $onehot(m2_ctrl.fwd[r].m2_src));
	end

	always_comb begin
		ex_fwd = ex_raw;
		ex_fwd.reg_data = ex_opnd;
		m1_fwd = m1_raw;
		m1_fwd.reg_data = m1_opnd;
		m2_fwd = m2_raw;
		m2_fwd.reg_data = m2_opnd;
		m2_fwd.result = (m2_ctrl.wb_sel == bep_pkg::WB_CSR) ? csr_rdata_i : m2_raw.result;
	end

	// control words
	always_ff @(posedge clk) begin
		if (!rst_n) ex_ctrl <= '0;
		else if (!stall_vec_i[0]) ex_ctrl <= issue_i ? ctrl_flow_i : '0;
		else ex_ctrl.fwd <= {to_own(ex_ctrl.fwd[1]), to_own(ex_ctrl.fwd[0])};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) m1_ctrl <= '0;
		else if (stall_vec_i[1]) m1_ctrl.fwd <= {to_own(m1_ctrl.fwd[1]), to_own(m1_ctrl.fwd[0])};
		else if (clr_vec_i[0] || stall_vec_i[0]) m1_ctrl <= '0;  // bubble
		else m1_ctrl <= ex_ctrl;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) m2_ctrl <= '0;
		else if (stall_vec_i[2]) m2_ctrl.fwd <= {to_own(m2_ctrl.fwd[1]), to_own(m2_ctrl.fwd[0])};
		else if (clr_vec_i[1] || stall_vec_i[1]) m2_ctrl <= '0;
		else m2_ctrl <= m1_ctrl;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || clr_vec_i[2] || stall_vec_i[2]) wb_ctrl <= '0;
		else wb_ctrl <= m2_ctrl;
	end

	// data words, hold cycles capture the forwarded operands
	always_ff @(posedge clk) begin
		ex_raw <= stall_vec_i[0] ? ex_fwd : data_flow_i;
		m1_raw <= stall_vec_i[1] ? m1_fwd
			: '{pc: ex_raw.pc, reg_data: ex_opnd, result: alu_result_i};
		m2_raw <= stall_vec_i[2] ? m2_fwd : m1_fwd;
		wb_data <= m2_fwd;  // wb never holds
	end

	assign ex_ctrl_o = ex_ctrl;
	assign ex_rd_o = ex_opnd[0];
	assign ex_rj_o = ex_opnd[1];

	assign csr_req_o.commit = m2_ctrl.valid && m2_ctrl.wb_sel == bep_pkg::WB_CSR
		&& !stall_vec_i[2] && !clr_vec_i[2];
	assign csr_req_o.op = m2_ctrl.csr_op;
	assign csr_req_o.num = m2_ctrl.instr.csr.num;
	assign csr_req_o.wdata = m2_opnd[0];
	assign csr_req_o.wmask = m2_opnd[1];

	assign forwarding_data_o.m1 = m1_ctrl.valid ? m1_raw.result : '0;
	assign forwarding_data_o.m2 = m2_ctrl.valid ? m2_fwd.result : '0;
	assign forwarding_data_o.wb = wb_ctrl.valid ? wb_data.result : '0;

	assign reg_wr_o.addr = wb_ctrl.valid ? wb_ctrl.w_reg : '0;
	assign reg_wr_o.data = wb_ctrl.valid ? wb_data.result : '0;

endmodule

// File: source/backend_top.sv
`include "bep_defs.svh"
`timescale 1ns/1ps

module backend_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     issue_i,
	input  bep_pkg::ctrl_flow_t      ctrl_flow_i,
	input  bep_pkg::data_flow_t      data_flow_i,
	input  logic [2:0]               stall_vec_i,  // [0] ex, [1] m1, [2] m2
	input  logic [2:0]               clr_vec_i,
	input  bep_pkg::fwd_src_t        forwarding_src_i,
	output bep_pkg::fwd_out_t        forwarding_data_o,
	output bep_pkg::reg_wr_t         reg_wr_o,
	output logic [`BEP_TIMER_W-1:0]  timer_data_o,
	output logic [`BEP_XLEN-1:0]     tid_o
);

	bep_pkg::ctrl_flow_t   ex_ctrl;
	bep_pkg::csr_req_t     csr_req;
	logic [`BEP_XLEN-1:0]  ex_rj, ex_rd;
	logic [`BEP_XLEN-1:0]  alu_result;
	logic [`BEP_XLEN-1:0]  csr_rdata;

	stage_regs u_stage_regs (
		.clk               (clk),
		.rst_n             (rst_n),
		.issue_i           (issue_i),
		.ctrl_flow_i       (ctrl_flow_i),
		.data_flow_i       (data_flow_i),
		.stall_vec_i       (stall_vec_i),
		.clr_vec_i         (clr_vec_i),
		.forwarding_src_i  (forwarding_src_i),
		.alu_result_i      (alu_result),
		.csr_rdata_i       (csr_rdata),
		.ex_ctrl_o         (ex_ctrl),
		.ex_rj_o           (ex_rj),
		.ex_rd_o           (ex_rd),
		.csr_req_o         (csr_req),
		.forwarding_data_o (forwarding_data_o),
		.reg_wr_o          (reg_wr_o)
	);

	exec_alu u_exec_alu (
		.ctrl_i       (ex_ctrl),
		.opnd_rj_i    (ex_rj),
		.opnd_rd_i    (ex_rd),
		.alu_result_o (alu_result)
	);

	csr_file u_csr_file (
		.clk          (clk),
		.rst_n        (rst_n),
		.csr_req_i    (csr_req),
		.csr_rdata_o  (csr_rdata),
		.timer_data_o (timer_data_o),
		.tid_o        (tid_o)
	);

endmodule

// File: test/tb_backend.sv
`include "bep_defs.svh"
`timescale 1ns/1ps

module tb_backend;

	localparam int MAX_CYCLES = 400;  // roughly twice the directed sequence

	logic                     clk, rst_n, issue_i;
	bep_pkg::ctrl_flow_t      ctrl_flow_i;
	bep_pkg::data_flow_t      data_flow_i;
	logic [2:0]               stall_vec_i, clr_vec_i;
	bep_pkg::fwd_src_t        forwarding_src_i;
	bep_pkg::fwd_out_t        forwarding_data_o;
	bep_pkg::reg_wr_t         reg_wr_o;
	logic [`BEP_TIMER_W-1:0]  timer_data_o;
	logic [`BEP_XLEN-1:0]     tid_o;

	logic [31:0]           lfsr = 32'h17e9;
	logic [`BEP_XLEN-1:0]  csr_shadow [3];  // save0, save1, tid
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycle_cnt = 0;

	backend_top dut (
		.clk               (clk),
		.rst_n             (rst_n),
		.issue_i           (issue_i),
		.ctrl_flow_i       (ctrl_flow_i),
		.data_flow_i       (data_flow_i),
		.stall_vec_i       (stall_vec_i),
		.clr_vec_i         (clr_vec_i),
		.forwarding_src_i  (forwarding_src_i),
		.forwarding_data_o (forwarding_data_o),
		.reg_wr_o          (reg_wr_o),
		.timer_data_o      (timer_data_o),
		.tid_o             (tid_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= MAX_CYCLES);
		$display("timeout: run stopped after %0d cycles without finishing", MAX_CYCLES);
		$display("sim failed");
		$finish;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_word(int nbits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return v;
	endfunction

	function automatic logic [4:0] rand_reg();
		return 5'(rand_word(4)) + 5'd1;  // never r0
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg_wr(string what, bep_pkg::reg_wr_t got, bep_pkg::reg_wr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: %s got r%0d=%h expected r%0d=%h", $time, what,
				got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	task automatic check_timer(string what, logic [`BEP_TIMER_W-1:0] got,
			logic [`BEP_TIMER_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(string name, int err_at_start);
		tests++;
		$display("test %s: %s", name, (errors == err_at_start) ? "ok" : "FAIL");
	endtask

	function automatic bep_pkg::ctrl_flow_t base_ctrl(logic [4:0] w_reg);
		bep_pkg::ctrl_flow_t c;
		c = '0;
		c.valid = 1'b1;
		c.w_reg = w_reg;
		for (int r = 0; r < 2; r++) begin
			c.fwd[r].ex_src = 4'b0001;  // own operand everywhere
			c.fwd[r].m1_src = 3'b001;
			c.fwd[r].m2_src = 2'b01;
		end
		return c;
	endfunction

	function automatic bep_pkg::data_flow_t rand_data();
		bep_pkg::data_flow_t d;
		d.pc = rand_word(32);
		d.reg_data[0] = rand_word(32);
		d.reg_data[1] = rand_word(32);
		d.result = '0;
		return d;
	endfunction

	// expected alu result, a is rj and b is rd or the immediate
	function automatic logic [31:0] alu_model(bep_pkg::alu_op_e op, logic [31:0] rj,
			logic [31:0] rd, logic use_imm, logic [11:0] imm);
		logic [31:0] b;
		logic [4:0]  sh;
		b = use_imm ? {{20{imm[11]}}, imm} : rd;
		sh = b[4:0];
		case (op)
			bep_pkg::ALU_ADD:  return rj + b;
			bep_pkg::ALU_SUB:  return rj + ~b + 32'd1;
			bep_pkg::ALU_AND:  return rj & b;
			bep_pkg::ALU_OR:   return rj | b;
			bep_pkg::ALU_XOR:  return rj ^ b;
			bep_pkg::ALU_SLT:  return {31'b0, (rj ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
			bep_pkg::ALU_SLTU: return {31'b0, rj < b};
			bep_pkg::ALU_SLL:  return rj << sh;
			bep_pkg::ALU_SRL:  return rj >> sh;
			bep_pkg::ALU_SRA:  return (rj >> sh) | (~(32'hffff_ffff >> sh) & {32{rj[31]}});
			bep_pkg::ALU_LUI:  return {imm, 20'b0};
			default:           return '0;
		endcase
	endfunction

	// issue one instruction, wb shows it on the 4th edge after the drive
	task automatic issue_and_check(string what, bep_pkg::ctrl_flow_t c,
			bep_pkg::data_flow_t d, bep_pkg::reg_wr_t exp);
		issue_i = 1'b1;
		ctrl_flow_i = c;
		data_flow_i = d;
		next_cycle();
		issue_i = 1'b0;
		ctrl_flow_i = '0;
		next_cycle();
		// csr results only exist from m2 on
		if (c.wb_sel == bep_pkg::WB_ALU) begin
			check_word({what, " m1 forward"}, forwarding_data_o.m1, exp.data);
		end
		next_cycle();
		check_reg_wr({what, " early"}, reg_wr_o, '0);
		check_word({what, " m2 forward"}, forwarding_data_o.m2, exp.data);
		next_cycle();
		check_reg_wr(what, reg_wr_o, exp);
		check_word({what, " wb forward"}, forwarding_data_o.wb, exp.data);
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		check_reg_wr("reg_wr after reset", reg_wr_o, '0);
		check_word("m1 forward after reset", forwarding_data_o.m1, '0);
		check_word("m2 forward after reset", forwarding_data_o.m2, '0);
		check_word("wb forward after reset", forwarding_data_o.wb, '0);
		check_word("tid after reset", tid_o, '0);
		finish_test("reset", e0);
	endtask

	task automatic test_alu();
		bep_pkg::ctrl_flow_t c;
		bep_pkg::data_flow_t d;
		bep_pkg::reg_wr_t    exp;
		int e0;
		e0 = errors;
		for (int k = 0; k <= int'(bep_pkg::ALU_LUI); k++) begin
			for (int ui = 0; ui < 2; ui++) begin
				c = base_ctrl(rand_reg());
				c.alu_op = bep_pkg::alu_op_e'(k);
				c.use_imm = ui[0];
				c.instr.alu.imm = rand_word(`BEP_IMM_W);
				d = rand_data();
				exp.addr = c.w_reg;
				exp.data = alu_model(c.alu_op, d.reg_data[1], d.reg_data[0], c.use_imm,
					c.instr.alu.imm);
				issue_and_check($sformatf("alu op %0d imm %0d", k, ui), c, d, exp);
			end
		end
		finish_test("alu", e0);
	endtask

	task automatic test_forward();
		bep_pkg::ctrl_flow_t c;
		bep_pkg::data_flow_t d;
		bep_pkg::reg_wr_t    exp;
		int e0;
		e0 = errors;
		forwarding_src_i.pipe0 = {rand_word(32), rand_word(32), rand_word(32)};
		forwarding_src_i.pipe1 = {rand_word(32), rand_word(32), rand_word(32)};
		c = base_ctrl(rand_reg());
		c.alu_op = bep_pkg::ALU_ADD;
		c.fwd[1].pipe_sel = 1'b1;
		c.fwd[1].ex_src = 4'b0100;  // m2 tap
		d = rand_data();
		exp.addr = c.w_reg;
		exp.data = forwarding_src_i.pipe1[1] + d.reg_data[0];
		issue_and_check("rj from pipe1 m2", c, d, exp);
		finish_test("forward", e0);
	endtask

	task automatic test_hold();
		bep_pkg::ctrl_flow_t c;
		bep_pkg::data_flow_t d;
		bep_pkg::reg_wr_t    exp;
		logic [31:0]         v1;
		int e0;
		e0 = errors;
		c = base_ctrl(rand_reg());
		c.alu_op = bep_pkg::ALU_ADD;
		c.fwd[1].ex_src = 4'b0010;  // m1 tap of pipe 0
		d = rand_data();
		v1 = rand_word(32);
		exp.addr = c.w_reg;
		exp.data = v1 + d.reg_data[0];
		issue_i = 1'b1;
		ctrl_flow_i = c;
		data_flow_i = d;
		next_cycle();
		issue_i = 1'b0;
		ctrl_flow_i = '0;
		stall_vec_i[0] = 1'b1;
		forwarding_src_i.pipe0[0] = v1;
		next_cycle();
		forwarding_src_i.pipe0[0] = ~v1;  // too late, already captured
		repeat (2) next_cycle();
		stall_vec_i[0] = 1'b0;
		repeat (2) next_cycle();
		check_reg_wr("held add early", reg_wr_o, '0);
		next_cycle();
		check_reg_wr("held add", reg_wr_o, exp);
		finish_test("hold", e0);
	endtask

	task automatic test_clear();
		bep_pkg::ctrl_flow_t c;
		int e0;
		e0 = errors;
		c = base_ctrl(rand_reg());
		c.alu_op = bep_pkg::ALU_OR;
		issue_i = 1'b1;
		ctrl_flow_i = c;
		data_flow_i = rand_data();
		next_cycle();
		issue_i = 1'b0;
		ctrl_flow_i = '0;
		next_cycle();
		clr_vec_i[1] = 1'b1;  // instruction sits in m1 now
		next_cycle();
		clr_vec_i[1] = 1'b0;
		repeat (2) begin
			next_cycle();
			check_reg_wr("flushed write", reg_wr_o, '0);
		end
		finish_test("clear", e0);
	endtask

	task automatic csr_access(bep_pkg::csr_op_e op, logic [13:0] num, logic [31:0] wdata,
			logic [31:0] mask);
		bep_pkg::ctrl_flow_t c;
		bep_pkg::data_flow_t d;
		bep_pkg::reg_wr_t    exp;
		logic [31:0]         old;
		int slot;
		case (num)
			`BEP_CSR_SAVE0: slot = 0;
			`BEP_CSR_SAVE1: slot = 1;
			`BEP_CSR_TID:   slot = 2;
			default:        slot = -1;
		endcase
		old = (slot < 0) ? '0 : csr_shadow[slot];
		c = base_ctrl(rand_reg());
		c.wb_sel = bep_pkg::WB_CSR;
		c.csr_op = op;
		c.instr.csr.num = num;
		d = '0;
		d.reg_data[0] = wdata;
		d.reg_data[1] = mask;
		exp.addr = c.w_reg;
		exp.data = old;
		if (slot >= 0 && op == bep_pkg::CSR_WR) csr_shadow[slot] = wdata;
		if (slot >= 0 && op == bep_pkg::CSR_XCHG) begin
			// each set mask bit takes the new bit
			for (int i = 0; i < 32; i++) begin
				csr_shadow[slot][i] = mask[i] ? wdata[i] : old[i];
			end
		end
		issue_and_check($sformatf("csr op %0d num %h", op, num), c, d, exp);
		check_word("tid_o", tid_o, csr_shadow[2]);
	endtask

	task automatic test_csr();
		int e0;
		e0 = errors;
		csr_access(bep_pkg::CSR_WR, `BEP_CSR_SAVE0, rand_word(32), '0);
		csr_access(bep_pkg::CSR_WR, `BEP_CSR_SAVE0, rand_word(32), '0);
		csr_access(bep_pkg::CSR_XCHG, `BEP_CSR_SAVE0, rand_word(32), rand_word(32));
		csr_access(bep_pkg::CSR_RD, `BEP_CSR_SAVE0, rand_word(32), rand_word(32));
		csr_access(bep_pkg::CSR_XCHG, `BEP_CSR_SAVE1, rand_word(32), rand_word(32));
		csr_access(bep_pkg::CSR_WR, `BEP_CSR_TID, rand_word(32), '0);
		csr_access(bep_pkg::CSR_WR, 14'h123, rand_word(32), '0);  // unmapped
		csr_access(bep_pkg::CSR_RD, 14'h123, '0, '0);
		finish_test("csr", e0);
	endtask

	task automatic test_timer();
		logic [`BEP_TIMER_W-1:0] t0;
		int n;
		int e0;
		e0 = errors;
		t0 = timer_data_o;
		n = 4 + int'(rand_word(3));
		repeat (n) next_cycle();
		check_timer("timer delta", timer_data_o, t0 + n);
		finish_test("timer", e0);
	endtask

	initial begin
		rst_n = 1'b0;
		issue_i = 1'b0;
		ctrl_flow_i = '0;
		data_flow_i = '0;
		stall_vec_i = '0;
		clr_vec_i = '0;
		forwarding_src_i = '0;
		foreach (csr_shadow[i]) csr_shadow[i] = '0;
		repeat (4) @(posedge clk);
		#10;
		rst_n = 1'b1;
		test_reset();
		test_alu();
		test_forward();
		test_hold();
		test_clear();
		test_csr();
		test_timer();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) $display("sim passed");
		else $display("sim failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+source
source/bep_pkg.sv
source/operand_forward.sv
source/exec_alu.sv
source/csr_file.sv
source/stage_regs.sv
source/backend_top.sv
test/tb_backend.sv
